/* sim.f */
+incdir+.
rvfi_trace_pkg.sv
rvfi_trace_capture.sv
rvfi_trace_fifo.sv
rvfi_trace_retire.sv
rvfi_trace_top.sv
tb_clk_gen.sv
rvfi_trace_sva.sv
tb_rvfi_trace.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rvfi_trace
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_rvfi_trace.sv */
// Testbench for the retirement trace unit.
// Events are pulsed only between instructions, while instr_req and instr_ack are low.
// Outputs are read just after a rising edge (pre-edge values) or on the falling edge.

`timescale 1ns/1ps

`include "rvfi_trace_settings.svh"

module tb_rvfi_trace import rvfi_trace_pkg::*; ();

  // The timeout is sized from the number of instructions issued over all phases
  localparam int N_INSTR        = 59;
  localparam int TIMEOUT_CYCLES = N_INSTR * 40 + 200;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         instr_req;
  logic [`RVFI_PC_W-1:0]        instr_pc;
  logic                         instr_ack;
  logic                         irq_ack;
  logic [`RVFI_IRQ_ID_W-1:0]    irq_id;
  logic                         dbg_ack;
  logic [`RVFI_DBG_CAUSE_W-1:0] dbg_cause;
  logic                         ebreak;
  logic                         event_pending;
  logic                         retire_stall;
  logic                         rvfi_valid;
  logic [`RVFI_PC_W-1:0]        rvfi_pc;
  logic                         rvfi_intr;
  logic [`RVFI_IRQ_ID_W-1:0]    rvfi_irq_id;
  logic [`RVFI_DBG_CAUSE_W-1:0] rvfi_dbg;

  // Expected entries in retirement order
  trace_entry_t exp_q [$];

  // Model of the pending event as the core sees it
  trap_kind_e                   mdl_kind;
  logic [`RVFI_IRQ_ID_W-1:0]    mdl_id;
  logic [`RVFI_DBG_CAUSE_W-1:0] mdl_cause;
  logic                         mdl_ebreak;

  int          mismatch_cnt;
  int          other_cnt;
  int          accepted_cnt;
  int          retired_cnt;
  int          ack_rise_cnt;
  int          backpressure_cnt;
  int          cycle_cnt;
  int          stall_mode;
  logic        ack_prev;
  logic        req_prev;
  logic [15:0] lfsr_q = 16'd37980;

  tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(2)) i_clk_gen (
    .clk_i (clk_i),
    .rst_ni(rst_ni)
  );

  rvfi_trace_top i_rvfi_trace_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_req    (instr_req),
    .instr_pc     (instr_pc),
    .instr_ack    (instr_ack),
    .irq_ack      (irq_ack),
    .irq_id       (irq_id),
    .dbg_ack      (dbg_ack),
    .dbg_cause    (dbg_cause),
    .ebreak       (ebreak),
    .event_pending(event_pending),
    .retire_stall (retire_stall),
    .rvfi_valid   (rvfi_valid),
    .rvfi_pc      (rvfi_pc),
    .rvfi_intr    (rvfi_intr),
    .rvfi_irq_id  (rvfi_irq_id),
    .rvfi_dbg     (rvfi_dbg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step for every bit handed out
  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Builds the entry an instruction should retire with from the event held for it
  function automatic trace_entry_t expect_entry(input logic [`RVFI_PC_W-1:0] pc,
                                                input trap_kind_e kind,
                                                input logic [`RVFI_IRQ_ID_W-1:0] id,
                                                input logic [`RVFI_DBG_CAUSE_W-1:0] cause,
                                                input logic eb);
    trace_entry_t e;
    e.pc   = pc;
    e.kind = kind;
    e.info = '0;
    if (kind == TRAP_IRQ) begin
      e.info.irq_id = id;
    end else if (kind == TRAP_DEBUG) begin
      // An ebreak always reports cause 1
      e.info.dbg.cause = eb ? DBG_CAUSE_EBREAK : cause;
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    mismatch_cnt++;
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
  endtask

  task automatic check_ack(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      report_mismatch(name, 32'(exp), 32'(got));
    end
  endtask

  // Compares the RVFI outputs against the decode of one expected entry
  task automatic check_entry(input trace_entry_t exp);
    logic                         exp_intr;
    logic [`RVFI_IRQ_ID_W-1:0]    exp_id;
    logic [`RVFI_DBG_CAUSE_W-1:0] exp_dbg;
    exp_intr = (exp.kind == TRAP_IRQ);
    exp_id   = exp_intr ? exp.info.irq_id : '0;
    exp_dbg  = (exp.kind == TRAP_DEBUG) ? exp.info.dbg.cause : '0;
    if (rvfi_pc !== exp.pc) begin
      report_mismatch("rvfi_pc", exp.pc, rvfi_pc);
    end
    check_ack("rvfi_intr", exp_intr, rvfi_intr);
    if (rvfi_irq_id !== exp_id) begin
      report_mismatch("rvfi_irq_id", 32'(exp_id), 32'(rvfi_irq_id));
    end
    if (rvfi_dbg !== exp_dbg) begin
      report_mismatch("rvfi_dbg", 32'(exp_dbg), 32'(rvfi_dbg));
    end
  endtask

  task automatic finish_run();
    $display("Mismatches: %0d, other errors: %0d, retired: %0d of %0d",
             mismatch_cnt, other_cnt, retired_cnt, accepted_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Core-side driver
  ////////////////////////////////////////////////////////////////////////////

  // Advance one edge and drive the stall pattern of the current mode
  task automatic tick();
    logic [31:0] r;
    @(posedge clk_i);
    case (stall_mode)
      1: begin
        take_bits(1, r);
        retire_stall <= r[0];
      end
      2: begin
        // Stalled seven cycles in eight, so the buffer fills
        take_bits(3, r);
        retire_stall <= (r[2:0] != 3'd0);
      end
      default: retire_stall <= 1'b0;
    endcase
  endtask

  // Pulses one event and checks that it went pending
  task automatic pulse_event(input trap_kind_e kind, input logic eb);
    logic [31:0] id;
    logic [31:0] cause;
    take_bits(`RVFI_IRQ_ID_W, id);
    take_bits(`RVFI_DBG_CAUSE_W, cause);
    mdl_kind   = kind;
    mdl_id     = id[`RVFI_IRQ_ID_W-1:0];
    mdl_cause  = cause[`RVFI_DBG_CAUSE_W-1:0];
    mdl_ebreak = eb;
    if (kind == TRAP_IRQ) begin
      irq_ack <= 1'b1;
      irq_id  <= mdl_id;
    end else begin
      dbg_ack   <= 1'b1;
      dbg_cause <= mdl_cause;
      ebreak    <= eb;
    end
    tick();
    irq_ack <= 1'b0;
    dbg_ack <= 1'b0;
    ebreak  <= 1'b0;
    tick();
    check_ack("event_pending", 1'b1, event_pending);
  endtask

  // Full four-phase exchange for one instruction
  task automatic send_instr();
    logic [31:0] r;
    int          waits;
    take_bits(30, r);
    exp_q.push_back(expect_entry({r[29:0], 2'b00}, mdl_kind, mdl_id, mdl_cause,
                                 mdl_ebreak));
    instr_req <= 1'b1;
    instr_pc  <= {r[29:0], 2'b00};
    waits = 0;
    tick();
    while (!instr_ack) begin
      waits++;
      tick();
    end
    // More than one low sample means the full buffer held the ack back
    if (waits > 1) begin
      backpressure_cnt++;
    end
    mdl_kind = TRAP_NONE;
    accepted_cnt++;
    check_ack("event_pending", 1'b0, event_pending);
    instr_req <= 1'b0;
    tick();
    while (instr_ack) begin
      tick();
    end
  endtask

  // Either an irq, a debug entry or nothing ahead of the instruction
  task automatic send_random_instr();
    logic [31:0] r;
    take_bits(3, r);
    if (r[1:0] == 2'd0) begin
      pulse_event(TRAP_IRQ, 1'b0);
    end else if (r[1:0] == 2'd1) begin
      pulse_event(TRAP_DEBUG, r[2]);
    end
    send_instr();
  endtask

  initial begin
    instr_req    = 1'b0;
    instr_pc     = '0;
    irq_ack      = 1'b0;
    irq_id       = '0;
    dbg_ack      = 1'b0;
    dbg_cause    = '0;
    ebreak       = 1'b0;
    retire_stall = 1'b0;
    stall_mode   = 0;
    mdl_kind     = TRAP_NONE;
    mdl_id       = '0;
    mdl_cause    = '0;
    mdl_ebreak   = 1'b0;
    wait (rst_ni);
    tick();
    check_ack("rvfi_valid", 1'b0, rvfi_valid);
    check_ack("instr_ack", 1'b0, instr_ack);
    check_ack("event_pending", 1'b0, event_pending);
    // Plain instructions
    repeat (6) send_instr();
    // Interrupt tag followed by a plain instruction
    repeat (4) begin
      pulse_event(TRAP_IRQ, 1'b0);
      send_instr();
      send_instr();
    end
    // Debug entry with and without ebreak
    repeat (3) begin
      pulse_event(TRAP_DEBUG, 1'b0);
      send_instr();
      pulse_event(TRAP_DEBUG, 1'b1);
      send_instr();
      send_instr();
    end
    // Heavy stalls and then lighter random stalls
    stall_mode = 2;
    repeat (24) send_random_instr();
    stall_mode = 1;
    repeat (12) send_random_instr();
    stall_mode = 0;
    while (retired_cnt < accepted_cnt) begin
      tick();
    end
    // A few idle cycles catch any extra rvfi_valid
    repeat (6) tick();
    if (exp_q.size() != 0) begin
      other_cnt++;
      $display("%0d expected entries never retired", exp_q.size());
    end
    if (ack_rise_cnt != accepted_cnt) begin
      other_cnt++;
      $display("Handshake count wrong: %0d ack rises for %0d accepted instructions",
               ack_rise_cnt, accepted_cnt);
    end
    if (backpressure_cnt == 0) begin
      other_cnt++;
      $display("Stalls never filled the buffer enough to delay instr_ack");
    end
    finish_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  // Retired entries are compared in order against the reference queue
  always @(negedge clk_i) begin
    if (rst_ni && rvfi_valid) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("rvfi_valid at %0t with no instruction left to retire", $time);
      end else begin
        check_entry(exp_q.pop_front());
      end
      retired_cnt++;
    end
  end

  // The four-phase rule lets ack move only in response to req
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (instr_ack && !ack_prev) begin
        ack_rise_cnt++;
        if (!req_prev) begin
          other_cnt++;
          $display("instr_ack rose at %0t while instr_req was low", $time);
        end
      end
      if (!instr_ack && ack_prev && req_prev) begin
        other_cnt++;
        $display("instr_ack fell at %0t while instr_req was still high", $time);
      end
    end
    ack_prev = instr_ack;
    req_prev = instr_req;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    other_cnt++;
    $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run();
  end

endmodule

/* rvfi_trace_sva.sv */
// Assertions on event capture and debug reporting, bound into rvfi_trace_top.
// Assumes the core never pulses irq_ack and dbg_ack in the same cycle.
// The debug counter only bounds acks from above, a zero cause never retires it.

`timescale 1ns/1ps

`include "rvfi_trace_settings.svh"

module rvfi_trace_sva import rvfi_trace_pkg::*; (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         irq_ack,
  input logic                         dbg_ack,
  input logic [`RVFI_DBG_CAUSE_W-1:0] dbg_cause,
  input logic                         ebreak,
  input logic                         event_pending,
  input trace_entry_t                 push_entry,
  input logic                         rvfi_valid,
  input logic [`RVFI_DBG_CAUSE_W-1:0] rvfi_dbg
);

  // Cause the capture stage should store for this cycle's dbg_ack
  logic [`RVFI_DBG_CAUSE_W-1:0] exp_cause;
  // What capture would attach to the next pushed instruction
  trap_kind_e                   held_kind;
  logic [`RVFI_DBG_CAUSE_W-1:0] held_cause;
  // Debug acks that have not yet shown up on rvfi_dbg
  logic [7:0]                   dbg_outstanding_q;
  logic                         dbg_retired;

  assign exp_cause   = ebreak ? DBG_CAUSE_EBREAK : dbg_cause;
  assign held_kind   = push_entry.kind;
  assign held_cause  = push_entry.info.dbg.cause;
  assign dbg_retired = rvfi_valid && (rvfi_dbg != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_outstanding_q <= '0;
    end else if (dbg_ack && !dbg_retired) begin
      dbg_outstanding_q <= dbg_outstanding_q + 8'd1;
    end else if (!dbg_ack && dbg_retired) begin
      dbg_outstanding_q <= dbg_outstanding_q - 8'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////////////////////

  irq_sets_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack |=> event_pending)
    else $error("irq_ack was not followed by event_pending");

  // The stored cause must carry the ebreak override from the ack cycle
  dbg_cause_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_ack |=> event_pending && (held_kind == TRAP_DEBUG) &&
                (held_cause == $past(exp_cause)))
    else $error("dbg_ack did not leave the expected pending cause");

  no_ack_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    event_pending |-> !(irq_ack || dbg_ack))
    else $error("event ack pulsed while an event was already pending");

  dbg_report_has_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_retired |-> (dbg_outstanding_q != '0))
    else $error("rvfi_dbg reported without an earlier dbg_ack");

endmodule

bind rvfi_trace_top rvfi_trace_sva i_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .irq_ack      (irq_ack),
  .dbg_ack      (dbg_ack),
  .dbg_cause    (dbg_cause),
  .ebreak       (ebreak),
  .event_pending(event_pending),
  .push_entry   (push_entry),
  .rvfi_valid   (rvfi_valid),
  .rvfi_dbg     (rvfi_dbg)
);

/* tb_clk_gen.sv */
// Testbench clock and reset source.
// Reset is released with a non-blocking update on a rising edge.

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clk_i,
  output logic rst_ni
);

  // Free running clock, starts low at time zero
  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // Reset held low for the first RST_CYCLES rising edges
  initial begin
    rst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

endmodule

/* rvfi_trace_top.sv */
// Top level of the retirement trace unit.
// Capture feeds the in-order buffer, which retire drains under retire_stall.
// A stalled retire fills the buffer and then holds off instr_ack.

`timescale 1ns/1ps

`include "rvfi_trace_settings.svh"

module rvfi_trace_top import rvfi_trace_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         instr_req,
  input  logic [`RVFI_PC_W-1:0]        instr_pc,
  output logic                         instr_ack,
  input  logic                         irq_ack,
  input  logic [`RVFI_IRQ_ID_W-1:0]    irq_id,
  input  logic                         dbg_ack,
  input  logic [`RVFI_DBG_CAUSE_W-1:0] dbg_cause,
  input  logic                         ebreak,
  output logic                         event_pending,
  input  logic                         retire_stall,
  output logic                         rvfi_valid,
  output logic [`RVFI_PC_W-1:0]        rvfi_pc,
  output logic                         rvfi_intr,
  output logic [`RVFI_IRQ_ID_W-1:0]    rvfi_irq_id,
  output logic [`RVFI_DBG_CAUSE_W-1:0] rvfi_dbg
);

  // Capture to buffer
  logic         push_valid;
  trace_entry_t push_entry;
  logic         full;

  // Buffer to retire
  trace_entry_t head;
  logic         empty;
  logic         pop;

  rvfi_trace_capture i_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_req    (instr_req),
    .instr_pc     (instr_pc),
    .instr_ack    (instr_ack),
    .irq_ack      (irq_ack),
    .irq_id       (irq_id),
    .dbg_ack      (dbg_ack),
    .dbg_cause    (dbg_cause),
    .ebreak       (ebreak),
    .event_pending(event_pending),
    .full         (full),
    .push_valid   (push_valid),
    .push_entry   (push_entry)
  );

  rvfi_trace_fifo i_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_valid(push_valid),
    .push_entry(push_entry),
    .full      (full),
    .pop       (pop),
    .head      (head),
    .empty     (empty)
  );

  rvfi_trace_retire i_retire (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .empty       (empty),
    .head        (head),
    .pop         (pop),
    .retire_stall(retire_stall),
    .rvfi_valid  (rvfi_valid),
    .rvfi_pc     (rvfi_pc),
    .rvfi_intr   (rvfi_intr),
    .rvfi_irq_id (rvfi_irq_id),
    .rvfi_dbg    (rvfi_dbg)
  );

endmodule

/* rvfi_trace_retire.sv */
// Retire stage, presents one buffered entry per cycle on RVFI-style outputs.
// All RVFI outputs are registered; rvfi_valid is high for one cycle per entry.
// rvfi_pc and rvfi_irq_id hold their last value while rvfi_valid is low.

`timescale 1ns/1ps

`include "rvfi_trace_settings.svh"

module rvfi_trace_retire import rvfi_trace_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Buffer head
  input  logic                         empty,
  input  trace_entry_t                 head,
  output logic                         pop,
  // External back-pressure
  input  logic                         retire_stall,
  // Retirement trace
  output logic                         rvfi_valid,
  output logic [`RVFI_PC_W-1:0]        rvfi_pc,
  output logic                         rvfi_intr,
  output logic [`RVFI_IRQ_ID_W-1:0]    rvfi_irq_id,
  output logic [`RVFI_DBG_CAUSE_W-1:0] rvfi_dbg
);

  // Decoded trap fields of the current head
  logic                         intr_d;
  logic [`RVFI_IRQ_ID_W-1:0]    irq_id_d;
  logic [`RVFI_DBG_CAUSE_W-1:0] dbg_d;

  // Take the head whenever there is one and nobody holds us off
  assign pop = !empty && !retire_stall;

  ////////////////////////////////////////////////////////////////////////////
  // Trap info decode
  ////////////////////////////////////////////////////////////////////////////

  // Fields of the kind that is absent read as zero
  always_comb begin
    intr_d   = 1'b0;
    irq_id_d = '0;
    dbg_d    = '0;
    case (head.kind)
      TRAP_IRQ: begin
        intr_d   = 1'b1;
        irq_id_d = head.info.irq_id;
      end
      TRAP_DEBUG: begin
        dbg_d = head.info.dbg.cause;
      end
      default: begin
        intr_d = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Valid and the trap flags only stand while an entry is shown
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid <= 1'b0;
      rvfi_intr  <= 1'b0;
      rvfi_dbg   <= '0;
    end else begin
      rvfi_valid <= pop;
      rvfi_intr  <= pop && intr_d;
      rvfi_dbg   <= pop ? dbg_d : '0;
    end
  end

  // PC and interrupt id are payload and only move on a pop
  always_ff @(posedge clk_i) begin
    if (pop) begin
      rvfi_pc     <= head.pc;
      rvfi_irq_id <= irq_id_d;
    end
  end

endmodule

/* rvfi_trace_fifo.sv */
// In-order trace buffer between capture and retire.
// Depth comes from RVFI_FIFO_DEPTH and must be a power of two.
// Pushes while full and pops while empty are ignored.
// The head is read combinationally from the storage array.

`timescale 1ns/1ps

`include "rvfi_trace_settings.svh"

module rvfi_trace_fifo import rvfi_trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Push side, driven by capture
  input  logic         push_valid,
  input  trace_entry_t push_entry,
  output logic         full,
  // Pop side, driven by retire
  input  logic         pop,
  output trace_entry_t head,
  output logic         empty
);

  // Address bits, pointers carry one extra wrap bit
  localparam int AW = $clog2(`RVFI_FIFO_DEPTH);

  trace_entry_t mem_q [`RVFI_FIFO_DEPTH];

  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;

  // Qualified transfers for this cycle
  logic do_push;
  logic do_pop;

  ////////////////////////////////////////////////////////////////////////////
  // Status flags
  ////////////////////////////////////////////////////////////////////////////

  // Same address with different wrap bits means the array is full
  assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign empty = (wr_ptr_q == rd_ptr_q);

  assign do_push = push_valid && !full;
  assign do_pop  = pop && !empty;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////////////////////

  // Push and pop are independent, so both may advance in one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[AW-1:0]] <= push_entry;
    end
  end

  // An entry written on one edge shows at the head right after it
  assign head = mem_q[rd_ptr_q[AW-1:0]];

endmodule

/* rvfi_trace_capture.sv */
// Core-facing capture stage of the trace unit.
// The core must pulse irq_ack or dbg_ack only while event_pending is low,
// and never both in one cycle. Only one event is held at a time.
// The instruction port is four-phase; a full buffer delays the ack.

`timescale 1ns/1ps

`include "rvfi_trace_settings.svh"

module rvfi_trace_capture import rvfi_trace_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Instruction port, four-phase req/ack
  input  logic                         instr_req,
  input  logic [`RVFI_PC_W-1:0]        instr_pc,
  output logic                         instr_ack,
  // Event acknowledgements from the core
  input  logic                         irq_ack,
  input  logic [`RVFI_IRQ_ID_W-1:0]    irq_id,
  input  logic                         dbg_ack,
  input  logic [`RVFI_DBG_CAUSE_W-1:0] dbg_cause,
  input  logic                         ebreak,
  output logic                         event_pending,
  // Push side of the trace buffer
  input  logic                         full,
  output logic                         push_valid,
  output trace_entry_t                 push_entry
);

  // Idle waits for a request, acked waits for the core to drop it
  typedef enum logic {
    CAP_IDLE  = 1'b0,
    CAP_ACKED = 1'b1
  } cap_state_e;

  cap_state_e state_q;
  cap_state_e state_d;

  // Pending event, kind is control state and info is payload
  trap_kind_e pend_kind_q;
  trap_info_u pend_info_q;

  // Event as it would be stored from this cycle's acknowledgement
  trap_kind_e new_kind;
  trap_info_u new_info;

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase instruction port
  ////////////////////////////////////////////////////////////////////////////

  // A push happens on the same edge that raises the ack
  assign push_valid = (state_q == CAP_IDLE) && instr_req && !full;
  assign instr_ack  = (state_q == CAP_ACKED);

  always_comb begin
    state_d = state_q;
    case (state_q)
      CAP_IDLE: begin
        if (push_valid) begin
          state_d = CAP_ACKED;
        end
      end
      CAP_ACKED: begin
        // Ack falls on the edge after the core releases its request
        if (!instr_req) begin
          state_d = CAP_IDLE;
        end
      end
      default: state_d = CAP_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending event register
  ////////////////////////////////////////////////////////////////////////////

  // Ebreak overrides whatever cause the core reported
  always_comb begin
    new_kind = TRAP_NONE;
    new_info = '0;
    if (irq_ack) begin
      new_kind        = TRAP_IRQ;
      new_info.irq_id = irq_id;
    end else if (dbg_ack) begin
      new_kind           = TRAP_DEBUG;
      new_info.dbg.cause = ebreak ? DBG_CAUSE_EBREAK : dbg_cause;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CAP_IDLE;
      pend_kind_q <= TRAP_NONE;
    end else begin
      state_q <= state_d;
      // A fresh ack wins, so an ack in a push cycle waits for the next one
      if (irq_ack || dbg_ack) begin
        pend_kind_q <= new_kind;
      end else if (push_valid) begin
        pend_kind_q <= TRAP_NONE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (irq_ack || dbg_ack) begin
      pend_info_q <= new_info;
    end
  end

  assign event_pending = (pend_kind_q != TRAP_NONE);

  // Attach the held event, info is forced to zero on plain instructions
  assign push_entry.pc   = instr_pc;
  assign push_entry.kind = pend_kind_q;
  assign push_entry.info = event_pending ? pend_info_q : '0;

endmodule

/* rvfi_trace_pkg.sv */
// Types shared by the capture, buffer and retire stages.
// The trap info field is sized by the interrupt id; a debug cause sits in
// its low bits and the bits above it are zero.

`include "rvfi_trace_settings.svh"

package rvfi_trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Trap kinds and trap payload
  ////////////////////////////////////////////////////////////////////////////

  // Kind of event attached to a retired instruction
  typedef enum logic [1:0] {
    TRAP_NONE  = 2'd0,
    TRAP_IRQ   = 2'd1,
    TRAP_DEBUG = 2'd2
  } trap_kind_e;

  // Debug view of the info field, cause zero extended into the upper bits
  typedef struct packed {
    logic [`RVFI_IRQ_ID_W-`RVFI_DBG_CAUSE_W-1:0] zero;
    logic [`RVFI_DBG_CAUSE_W-1:0]                cause;
  } trap_dbg_t;

  // One info word, read as an interrupt id or as a debug cause by kind
  typedef union packed {
    logic [`RVFI_IRQ_ID_W-1:0] irq_id;
    trap_dbg_t                 dbg;
  } trap_info_u;

  // Cause value reported whenever debug entry came from an ebreak
  localparam logic [`RVFI_DBG_CAUSE_W-1:0] DBG_CAUSE_EBREAK = 3'd1;

  ////////////////////////////////////////////////////////////////////////////
  // Buffer entry
  ////////////////////////////////////////////////////////////////////////////

  // Everything needed to retire one instruction, 39 bits with default sizes
  typedef struct packed {
    logic [`RVFI_PC_W-1:0] pc;
    trap_kind_e            kind;
    trap_info_u            info;
  } trace_entry_t;

endpackage

/* rvfi_trace_settings.svh */
// Build-time sizes for the retirement trace unit.
// RVFI_FIFO_DEPTH must be a power of two because the buffer wraps its pointers.
// RVFI_DBG_CAUSE_W must not exceed RVFI_IRQ_ID_W, as both share one info field.

`ifndef RVFI_TRACE_SETTINGS_SVH
`define RVFI_TRACE_SETTINGS_SVH

// Width of the instruction PC carried with every entry
`define RVFI_PC_W 32

// Number of entries in the in-order trace buffer
`define RVFI_FIFO_DEPTH 4

// Interrupt id width, which also sizes the shared trap info field
`define RVFI_IRQ_ID_W 5

// Debug cause width as reported on rvfi_dbg
`define RVFI_DBG_CAUSE_W 3

`endif
